//--- src/radio_io_consts.svh
// ################################################
// sample and error counter widths, register map
// and control bit positions for the radio I/O
// ################################################

`ifndef RADIO_IO_CONSTS_SVH
`define RADIO_IO_CONSTS_SVH

// transceiver sample width, one I or Q value
`define RADIO_SAMPLE_W 12

// saturating framing error counter
`define RADIO_ERRCNT_W 16

// register map
`define RADIO_ADDR_CTRL   2'd0
`define RADIO_ADDR_STATUS 2'd1

// bits of the control register
`define RADIO_CTRL_MIMO_BIT 0
`define RADIO_CTRL_TXEN_BIT 1

`endif

//--- src/radio_io_pkg.sv
// ################################################
// types for the radio I/O: samples, bus halves,
// register port words and the deframer states
// ################################################

`default_nettype none

`include "radio_io_consts.svh"

package radio_io_pkg;

  // one signed I or Q value from the transceiver
  typedef logic signed [`RADIO_SAMPLE_W-1:0] sample_t;

  // both channels of one sample period
  typedef struct packed {
    sample_t i0;
    sample_t q0;
    sample_t i1;
    sample_t q1;
  } iq_pair_t;

  // one radio_clk cycle on the shared port
  // rise half carries I, fall half carries Q
  typedef struct packed {
    sample_t rise_data;
    sample_t fall_data;
    logic    rise_frame;
    logic    fall_frame;
  } bus_half_t;

  typedef logic [1:0]  cfg_addr_t;
  typedef logic [15:0] cfg_word_t;

  typedef enum logic {
    WAIT_CH0,
    WAIT_CH1
  } deframe_state_e;

endpackage

`default_nettype wire

//--- src/radio_cfg_regs.sv
// ################################################
// four-phase register slave with control bits
// and a clear-on-write framing error counter
// ################################################

`default_nettype none
`timescale 1ns/10ps

`include "radio_io_consts.svh"

module radio_cfg_regs (
  input  wire                     radio_clk,
  input  wire                     radio_rst,
  input  wire                     cfg_req_i,
  input  wire                     cfg_we_i,
  input  radio_io_pkg::cfg_addr_t cfg_addr_i,
  input  radio_io_pkg::cfg_word_t cfg_wdata_i,
  input  wire                     frame_err_i,
  output logic                    cfg_ack_o,
  output radio_io_pkg::cfg_word_t cfg_rdata_o,
  output logic                    mimo_o,
  output logic                    tx_en_o
);

  import radio_io_pkg::*;

  logic                       req_q;
  logic                       req_rise;
  logic                       status_clr;
  logic [`RADIO_ERRCNT_W-1:0] err_cnt;
  cfg_word_t                  rd_word;

  // one access per rising edge of req
  assign req_rise   = cfg_req_i & ~req_q;
  assign status_clr = req_rise & cfg_we_i & (cfg_addr_i == `RADIO_ADDR_STATUS);

  always_comb begin
    rd_word = '0;
    if (cfg_addr_i == `RADIO_ADDR_CTRL) begin
      rd_word[`RADIO_CTRL_MIMO_BIT] = mimo_o;
      rd_word[`RADIO_CTRL_TXEN_BIT] = tx_en_o;
    end else if (cfg_addr_i == `RADIO_ADDR_STATUS) begin
      rd_word = cfg_word_t'(err_cnt);
    end
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      req_q     <= 1'b0;
      cfg_ack_o <= 1'b0;
      mimo_o    <= 1'b0;
      tx_en_o   <= 1'b0;
      err_cnt   <= '0;
    end else begin
      req_q <= cfg_req_i;
      // ack follows req with one cycle of delay in both directions
      if (req_rise) begin
        cfg_ack_o <= 1'b1;
      end else if (!cfg_req_i) begin
        cfg_ack_o <= 1'b0;
      end
      if (req_rise && cfg_we_i && (cfg_addr_i == `RADIO_ADDR_CTRL)) begin
        mimo_o  <= cfg_wdata_i[`RADIO_CTRL_MIMO_BIT];
        tx_en_o <= cfg_wdata_i[`RADIO_CTRL_TXEN_BIT];
      end
      // clear wins over a new error in the same cycle
      if (status_clr) begin
        err_cnt <= '0;
      end else if (frame_err_i && (err_cnt != '1)) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  // read data is captured with the request and held through ack
  always_ff @(posedge radio_clk) begin
    if (req_rise) begin
      cfg_rdata_o <= rd_word;
    end
  end

  ack_needs_req : assert property (
    @(posedge radio_clk) disable iff (radio_rst)
    $rose(cfg_ack_o) |-> $past(cfg_req_i)
  );

endmodule

`default_nettype wire

//--- src/rx_deframer.sv
// ################################################
// receive deframer: bus halves to channel sample
// pairs with a strobe, MIMO framing error pulses
// ################################################

`default_nettype none
`timescale 1ns/10ps

module rx_deframer (
  input  wire                     radio_clk,
  input  wire                     radio_rst,
  input  wire                     mimo_i,
  input  radio_io_pkg::bus_half_t rx_bus_i,
  output radio_io_pkg::iq_pair_t  rx_samples_o,
  output logic                    rx_stb_o,
  output logic                    frame_err_o
);

  import radio_io_pkg::*;

  deframe_state_e state;

  // control path: state, strobe and error pulse
  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      state       <= WAIT_CH0;
      rx_stb_o    <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      rx_stb_o    <= 1'b0;
      frame_err_o <= 1'b0;
      if (!mimo_i) begin
        // siso passes a sample every cycle
        state    <= WAIT_CH0;
        rx_stb_o <= 1'b1;
      end else begin
        case (state)
          WAIT_CH0: begin
            if (rx_bus_i.rise_frame) begin
              state <= WAIT_CH1;
            end else begin
              // no frame marker, drop the cycle and keep looking
              frame_err_o <= 1'b1;
            end
          end
          WAIT_CH1: begin
            if (rx_bus_i.rise_frame) begin
              // a second channel 0, restart the pair from here
              frame_err_o <= 1'b1;
            end else begin
              state    <= WAIT_CH0;
              rx_stb_o <= 1'b1;
            end
          end
          default: begin
            state <= WAIT_CH0;
          end
        endcase
      end
    end
  end

  // sample registers
  always_ff @(posedge radio_clk) begin
    if (!mimo_i) begin
      rx_samples_o.i0 <= rx_bus_i.rise_data;
      rx_samples_o.q0 <= rx_bus_i.fall_data;
      rx_samples_o.i1 <= rx_bus_i.rise_data;
      rx_samples_o.q1 <= rx_bus_i.fall_data;
    end else if (rx_bus_i.rise_frame) begin
      // channel 0 cycle, also the resync point
      rx_samples_o.i0 <= rx_bus_i.rise_data;
      rx_samples_o.q0 <= rx_bus_i.fall_data;
    end else if (state == WAIT_CH1) begin
      rx_samples_o.i1 <= rx_bus_i.rise_data;
      rx_samples_o.q1 <= rx_bus_i.fall_data;
    end
  end

  // a MIMO pair takes two bus cycles, so strobes never touch
  mimo_stb_single : assert property (
    @(posedge radio_clk) disable iff (radio_rst)
    (mimo_i && rx_stb_o) |=> !(mimo_i && rx_stb_o)
  );

endmodule

`default_nettype wire

//--- src/tx_framer.sv
// ################################################
// transmit framer: sample pairs to bus halves,
// strobe pacing, frame bits and SISO substitution
// ################################################

`default_nettype none
`timescale 1ns/10ps

module tx_framer (
  input  wire                     radio_clk,
  input  wire                     radio_rst,
  input  wire                     mimo_i,
  input  wire                     tx_en_i,
  input  radio_io_pkg::iq_pair_t  tx_samples_i,
  output logic                    tx_stb_o,
  output radio_io_pkg::bus_half_t tx_bus_o
);

  import radio_io_pkg::*;

  logic    mimo_q;
  logic    en_q;
  logic    restart;
  sample_t ch1_i;
  sample_t ch1_q;
  sample_t siso_i;
  sample_t siso_q;

  // new mode or freshly enabled, begin again with an idle cycle
  assign restart = (mimo_i != mimo_q) | ~en_q;

  // siso sends channel 1 when channel 0 is all zero
  always_comb begin
    if ((tx_samples_i.i0 == '0) && (tx_samples_i.q0 == '0)) begin
      siso_i = tx_samples_i.i1;
      siso_q = tx_samples_i.q1;
    end else begin
      siso_i = tx_samples_i.i0;
      siso_q = tx_samples_i.q0;
    end
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      mimo_q   <= 1'b0;
      en_q     <= 1'b0;
      tx_stb_o <= 1'b0;
      tx_bus_o <= '0;
    end else begin
      mimo_q <= mimo_i;
      en_q   <= tx_en_i;
      if (!tx_en_i) begin
        tx_stb_o <= 1'b0;
        tx_bus_o <= '0;
      end else if (restart) begin
        tx_stb_o <= 1'b1;
        tx_bus_o <= '0;
      end else if (mimo_i) begin
        tx_stb_o <= ~tx_stb_o;
        if (tx_stb_o) begin
          tx_bus_o <= {tx_samples_i.i0, tx_samples_i.q0, 1'b1, 1'b1};
        end else begin
          tx_bus_o <= {ch1_i, ch1_q, 1'b0, 1'b0};
        end
      end else begin
        // single channel, marker on the falling half only
        tx_stb_o <= 1'b1;
        tx_bus_o <= {siso_i, siso_q, 1'b0, 1'b1};
      end
    end
  end

  // channel 1 kept from the strobe cycle for the next bus cycle
  always_ff @(posedge radio_clk) begin
    if (tx_stb_o) begin
      ch1_i <= tx_samples_i.i1;
      ch1_q <= tx_samples_i.q1;
    end
  end

  tx_off_silent : assert property (
    @(posedge radio_clk) disable iff (radio_rst)
    !tx_en_i |=> !tx_bus_o.rise_frame && !tx_bus_o.fall_frame && !tx_stb_o
  );

endmodule

`default_nettype wire

//--- src/radio_io_top.sv
// ################################################
// radio I/O top: register block, receive
// deframer and transmit framer
// ################################################

`default_nettype none
`timescale 1ns/10ps

module radio_io_top (
  input  wire                     radio_clk,
  input  wire                     radio_rst,
  // register port
  input  wire                     cfg_req_i,
  input  wire                     cfg_we_i,
  input  radio_io_pkg::cfg_addr_t cfg_addr_i,
  input  radio_io_pkg::cfg_word_t cfg_wdata_i,
  output logic                    cfg_ack_o,
  output radio_io_pkg::cfg_word_t cfg_rdata_o,
  // receive side
  input  radio_io_pkg::bus_half_t rx_bus_i,
  output radio_io_pkg::iq_pair_t  rx_samples_o,
  output logic                    rx_stb_o,
  // transmit side
  input  radio_io_pkg::iq_pair_t  tx_samples_i,
  output logic                    tx_stb_o,
  output radio_io_pkg::bus_half_t tx_bus_o
);

  logic mimo;
  logic tx_en;
  logic frame_err;

  radio_cfg_regs u_cfg_regs (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .frame_err_i (frame_err),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .mimo_o      (mimo),
    .tx_en_o     (tx_en)
  );

  rx_deframer u_rx_deframer (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .mimo_i       (mimo),
    .rx_bus_i     (rx_bus_i),
    .rx_samples_o (rx_samples_o),
    .rx_stb_o     (rx_stb_o),
    .frame_err_o  (frame_err)
  );

  tx_framer u_tx_framer (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .mimo_i       (mimo),
    .tx_en_i      (tx_en),
    .tx_samples_i (tx_samples_i),
    .tx_stb_o     (tx_stb_o),
    .tx_bus_o     (tx_bus_o)
  );

endmodule

`default_nettype wire

//--- testbench/radio_io_tb.sv
// ################################################
// testbench for radio_io_top: clock, reset,
// four-phase register access, golden vectors
// ################################################

`default_nettype none
`timescale 1ns/10ps

module radio_io_tb;

  import radio_io_pkg::*;

  localparam int WAIT_LIMIT = 16;

  logic      radio_clk;
  logic      radio_rst;
  logic      cfg_req;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  cfg_word_t cfg_wdata;
  logic      cfg_ack;
  cfg_word_t cfg_rdata;
  bus_half_t rx_bus;
  iq_pair_t  rx_samples;
  logic      rx_stb;
  iq_pair_t  tx_samples;
  logic      tx_stb;
  bus_half_t tx_bus;

  // golden line fields
  int          fd;
  int          nf;
  int          test_num;
  string       line;
  logic [7:0]  kind;
  logic [15:0] col_a, col_b, col_c, col_d, col_e, col_f, col_g, col_h, col_i;
  cfg_word_t   rd;

  logic rx_idle;
  logic run_aborted;
  int   test_checks;
  int   test_errs;
  int   checks_total;
  int   errs_total;
  int   tests_run;
  int   tests_failed;

  radio_io_top UUT (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .cfg_req_i    (cfg_req),
    .cfg_we_i     (cfg_we),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_ack_o    (cfg_ack),
    .cfg_rdata_o  (cfg_rdata),
    .rx_bus_i     (rx_bus),
    .rx_samples_o (rx_samples),
    .rx_stb_o     (rx_stb),
    .tx_samples_i (tx_samples),
    .tx_stb_o     (tx_stb),
    .tx_bus_o     (tx_bus)
  );

  always #4 radio_clk = ~radio_clk;

  // between rx vectors the transceiver keeps sending framed zero samples
  always @(posedge radio_clk) begin
    if (rx_idle) begin
      rx_bus <= {24'h000000, ~rx_bus.rise_frame, 1'b0};
    end
  end

  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    test_checks++;
    checks_total++;
    if (got !== exp) begin
      $display("FAIL test %0d %s: got %h expected %h", test_num, name, got, exp);
      test_errs++;
      errs_total++;
    end
  endtask

  // full four-phase handshake, read data taken while ack is high
  task automatic reg_access(input logic we, input cfg_addr_t addr, input cfg_word_t wdata,
                            output cfg_word_t rdata);
    int n;
    rdata = '0;
    @(posedge radio_clk);
    cfg_req   <= 1'b1;
    cfg_we    <= we;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    @(negedge radio_clk);
    n = 1;
    while (!cfg_ack && n < WAIT_LIMIT) begin
      @(negedge radio_clk);
      n++;
    end
    if (!cfg_ack) begin
      $display("test %0d: no ack for register access at address %0d", test_num, addr);
      run_aborted = 1'b1;
    end else begin
      rdata = cfg_rdata;
      @(posedge radio_clk);
      cfg_req <= 1'b0;
      @(negedge radio_clk);
      n = 1;
      while (cfg_ack && n < WAIT_LIMIT) begin
        @(negedge radio_clk);
        n++;
      end
      if (cfg_ack) begin
        $display("test %0d: ack stayed high after req was dropped", test_num);
        run_aborted = 1'b1;
      end
    end
  endtask

  task automatic align_tx_strobe();
    int n;
    n = 0;
    while (!tx_stb && n < WAIT_LIMIT) begin
      @(negedge radio_clk);
      n++;
    end
    if (!tx_stb) begin
      $display("test %0d: transmit strobe never went high", test_num);
      run_aborted = 1'b1;
    end
  endtask

  task automatic rx_line();
    if (rx_idle) begin
      rx_idle = 1'b0;
      @(posedge radio_clk);
      // let a pending channel 0 finish with a channel 1 filler
      if (rx_bus.rise_frame) begin
        rx_bus <= '0;
        @(posedge radio_clk);
      end
    end else begin
      @(posedge radio_clk);
    end
    rx_bus <= {col_a[11:0], col_b[11:0], col_c[0], 1'b0};
    @(negedge radio_clk);
    if (col_d[0]) begin
      compare_field("rx_stb_o", {15'h0, rx_stb}, col_e);
      if (col_e[0]) begin
        compare_field("rx_samples_o.i0", {4'h0, rx_samples.i0}, col_f);
        compare_field("rx_samples_o.q0", {4'h0, rx_samples.q0}, col_g);
        compare_field("rx_samples_o.i1", {4'h0, rx_samples.i1}, col_h);
        compare_field("rx_samples_o.q1", {4'h0, rx_samples.q1}, col_i);
      end
    end
  endtask

  task automatic tx_line();
    @(posedge radio_clk);
    tx_samples <= {col_a[11:0], col_b[11:0], col_c[11:0], col_d[11:0]};
    @(negedge radio_clk);
    if (col_e[0]) begin
      compare_field("tx_stb_o", {15'h0, tx_stb}, col_f);
      compare_field("tx_bus_o.rise_data", {4'h0, tx_bus.rise_data}, col_g);
      compare_field("tx_bus_o.fall_data", {4'h0, tx_bus.fall_data}, col_h);
      compare_field("tx_bus_o frame bits", {14'h0, tx_bus.rise_frame, tx_bus.fall_frame},
                    col_i);
    end
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      $display("test %0d ok: %0d checks", test_num, test_checks);
    end else begin
      $display("test %0d failed: %0d of %0d checks wrong", test_num, test_errs, test_checks);
      tests_failed++;
    end
    tests_run++;
    test_checks = 0;
    test_errs   = 0;
  endtask

  initial begin
    radio_clk    = 1'b0;
    radio_rst    = 1'b1;
    cfg_req      = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    rx_bus       = '0;
    tx_samples   = '0;
    rx_idle      = 1'b1;
    run_aborted  = 1'b0;
    test_num     = 0;
    test_checks  = 0;
    test_errs    = 0;
    checks_total = 0;
    errs_total   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge radio_clk);
    radio_rst <= 1'b0;
    @(negedge radio_clk);

    fd = $fopen("testbench/radio_io_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden vector file");
      run_aborted = 1'b1;
    end
    while (!run_aborted && $fgets(line, fd) > 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        nf = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h", test_num, kind,
                     col_a, col_b, col_c, col_d, col_e, col_f, col_g, col_h, col_i);
        if (nf != 11) begin
          $display("malformed golden line: %s", line);
          run_aborted = 1'b1;
        end else begin
          if (kind != "X") begin
            rx_idle = 1'b1;
          end
          case (kind)
            "W": reg_access(1'b1, col_a[1:0], col_b, rd);
            "R": begin
              reg_access(1'b0, col_a[1:0], '0, rd);
              if (!run_aborted) begin
                compare_field("cfg_rdata_o", rd, col_b);
              end
            end
            "X": rx_line();
            "T": tx_line();
            "A": align_tx_strobe();
            "E": close_test();
            default: begin
              $display("unknown vector kind in golden line: %s", line);
              run_aborted = 1'b1;
            end
          endcase
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks_total, errs_total);
    if (!run_aborted && errs_total == 0 && tests_run > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/radio_io_pkg.sv
src/radio_cfg_regs.sv
src/rx_deframer.sv
src/tx_framer.sv
src/radio_io_top.sv
testbench/radio_io_tb.sv

//--- Bender.yml
package:
  name: radio_io

sources:
  - include_dirs:
      - src
    files:
      - src/radio_io_pkg.sv
      - src/radio_cfg_regs.sv
      - src/rx_deframer.sv
      - src/tx_framer.sv
      - src/radio_io_top.sv
  - target: test
    files:
      - testbench/radio_io_tb.sv

//--- testbench/radio_io_golden.txt
# test kind a b c d e f g h i   (test in decimal, a..i in hex)
# W/R: a=addr b=data | X: a..c=rise fall frame d=chk e..i=stb i0 q0 i1 q1 | T: a..d=i0 q0 i1 q1 e=chk f..i=stb rise fall frames
1 T 000 000 000 000 1 0 000 000 0
1 R 1 0000 0 0 0 0 0 0 0
1 W 0 0003 0 0 0 0 0 0 0
1 R 0 0003 0 0 0 0 0 0 0
1 W 0 0000 0 0 0 0 0 0 0
1 R 0 0000 0 0 0 0 0 0 0
1 E 0 0 0 0 0 0 0 0 0
2 X 123 456 0 0 0 000 000 000 000
2 X 7ff 800 0 1 1 123 456 123 456
2 X 001 fff 1 1 1 7ff 800 7ff 800
2 X 000 000 0 1 1 001 fff 001 fff
2 E 0 0 0 0 0 0 0 0 0
3 W 0 0001 0 0 0 0 0 0 0
3 W 1 0000 0 0 0 0 0 0 0
3 R 1 0000 0 0 0 0 0 0 0
3 X 100 101 1 0 0 000 000 000 000
3 X 200 201 0 1 0 000 000 000 000
3 X 110 111 1 1 1 100 101 200 201
3 X 210 211 0 1 0 000 000 000 000
3 X 120 121 0 1 1 110 111 210 211
3 X 220 221 0 1 0 000 000 000 000
3 X 130 131 1 1 0 000 000 000 000
3 X 230 231 0 1 0 000 000 000 000
3 X 140 141 1 1 1 130 131 230 231
3 X 240 241 0 1 0 000 000 000 000
3 X 150 151 1 1 1 140 141 240 241
3 R 1 0002 0 0 0 0 0 0 0
3 W 1 0000 0 0 0 0 0 0 0
3 R 1 0000 0 0 0 0 0 0 0
3 W 0 0000 0 0 0 0 0 0 0
3 E 0 0 0 0 0 0 0 0 0
4 W 0 0003 0 0 0 0 0 0 0
4 A 0 0 0 0 0 0 0 0 0
4 T 111 222 333 444 0 0 000 000 0
4 T 111 222 333 444 0 0 000 000 0
4 T 555 666 777 888 1 0 111 222 3
4 T 555 666 777 888 1 1 333 444 0
4 T 99a abc def 012 1 0 555 666 3
4 T 99a abc def 012 1 1 777 888 0
4 T 000 000 000 000 1 0 99a abc 3
4 T 000 000 000 000 1 1 def 012 0
4 E 0 0 0 0 0 0 0 0 0
5 W 0 0002 0 0 0 0 0 0 0
5 A 0 0 0 0 0 0 0 0 0
5 T 321 654 aaa bbb 0 0 000 000 0
5 T 000 000 135 246 1 1 321 654 1
5 T 000 001 777 888 1 1 135 246 1
5 T 800 000 fff eee 1 1 000 001 1
5 T 000 000 000 000 1 1 800 000 1
5 E 0 0 0 0 0 0 0 0 0
6 W 0 0000 0 0 0 0 0 0 0
6 R 0 0000 0 0 0 0 0 0 0
6 T 5a5 a5a 123 321 1 0 000 000 0
6 T 7ff 7ff 7ff 7ff 1 0 000 000 0
6 T 001 002 003 004 1 0 000 000 0
6 E 0 0 0 0 0 0 0 0 0
